//--- verilog/exec_pkg.sv
/*
 * Shared widths and micro-op codes for the execute stage
 * Multiplier FSM state encodings
 */
`default_nettype none

package exec_pkg;

  // ------------------------------
  // Widths
  // ------------------------------

  // Data path and pc width
  localparam int XLEN = 32;

  // Completion tag from dispatch
  localparam int SEQ_NUM_BITS = 5;

  // Physical register tags preg and ppreg
  localparam int PHYS_ADDR_BITS = 6;

  // Micro-op field
  localparam int UOP_BITS = 4;

  // ------------------------------
  // Micro-op codes
  // ------------------------------

  // ALU codes
  localparam logic [UOP_BITS-1:0] UOP_ADD = 4'd0;
  localparam logic [UOP_BITS-1:0] UOP_SUB = 4'd1;
  localparam logic [UOP_BITS-1:0] UOP_AND = 4'd2;
  localparam logic [UOP_BITS-1:0] UOP_OR  = 4'd3;
  localparam logic [UOP_BITS-1:0] UOP_XOR = 4'd4;
  localparam logic [UOP_BITS-1:0] UOP_SLL = 4'd5;
  localparam logic [UOP_BITS-1:0] UOP_SRL = 4'd6;
  // Only code routed to the multiplier
  localparam logic [UOP_BITS-1:0] UOP_MUL = 4'd7;

  // ------------------------------
  // Multiplier FSM states
  // ------------------------------

  localparam logic [1:0] MUL_IDLE = 2'd0;
  localparam logic [1:0] MUL_CALC = 2'd1;
  localparam logic [1:0] MUL_DONE = 2'd2;

endpackage

`default_nettype wire

//--- verilog/dx_if.sv
/*
 * Dispatch-to-execute link with val/rdy handshake
 * Modports for the dispatch side and the unit side
 */
`timescale 1ns/100ps
`default_nettype none

interface dx_if;

  import exec_pkg::*;

  // Handshake
  logic                      val;
  logic                      rdy;

  // Micro-op payload
  logic [XLEN-1:0]           pc;
  logic [SEQ_NUM_BITS-1:0]   seq_num;
  logic [4:0]                waddr;
  logic [UOP_BITS-1:0]       uop;
  logic [XLEN-1:0]           op1;
  logic [XLEN-1:0]           op2;

  // Physical tags, passed through untouched
  logic [PHYS_ADDR_BITS-1:0] preg;
  logic [PHYS_ADDR_BITS-1:0] ppreg;

  // Sender of micro-ops
  modport dispatch (
    output val, pc, seq_num, waddr, uop, op1, op2, preg, ppreg,
    input  rdy
  );

  // Receiving functional unit
  modport unit (
    input  val, pc, seq_num, waddr, uop, op1, op2, preg, ppreg,
    output rdy
  );

endinterface

`default_nettype wire

//--- verilog/xw_if.sv
/*
 * Execute-to-writeback link with val/rdy handshake
 * Modports for the unit side and the writeback side
 */
`timescale 1ns/100ps
`default_nettype none

interface xw_if;

  import exec_pkg::*;

  logic                      val;
  logic                      rdy;

  // Result and its metadata
  logic [XLEN-1:0]           pc;
  logic [SEQ_NUM_BITS-1:0]   seq_num;
  logic [4:0]                waddr;
  logic [XLEN-1:0]           wdata;
  // Formed by the router, not the units
  logic                      wen;
  logic [PHYS_ADDR_BITS-1:0] preg;
  logic [PHYS_ADDR_BITS-1:0] ppreg;

  modport unit (
    output val, pc, seq_num, waddr, wdata, wen, preg, ppreg,
    input  rdy
  );

  modport wb (
    input  val, pc, seq_num, waddr, wdata, wen, preg, ppreg,
    output rdy
  );

endinterface

`default_nettype wire

//--- verilog/mul_step.sv
/*
 * One multiply iteration
 * Sums shifted copies of b for the low num_bits bits of a
 */
`timescale 1ns/100ps
`default_nettype none

module mul_step #(
  parameter int num_bits = 4
) (
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] out
);

  // Partial products for this slice of the multiplier operand
  always_comb begin
    out = '0;
    for (int i = 0; i < num_bits; i++) begin
      // Add b at bit position i when that multiplier bit is set
      if (a[i]) begin
        out = out + (b << i);
      end
    end
    // Upper product bits fall off, low 32 bits kept
  end

endmodule

`default_nettype wire

//--- verilog/iter_multiplier.sv
/*
 * Iterative multiplier, low 32 bits of the product
 * Idle / calc / done FSM, operand shift registers, accumulator
 */
`timescale 1ns/100ps
`default_nettype none

module iter_multiplier #(
  parameter int p_num_cycles = 8
) (
  input  logic   clk,
  input  logic   rst,
  dx_if.unit     d,
  xw_if.unit     w
);

  import exec_pkg::*;

  logic                      d_xfer;
  logic                      w_xfer;
  logic                      step_en;
  logic [1:0]                state;
  logic [1:0]                state_next;
  logic [5:0]                step_cnt;
  logic [XLEN-1:0]           opa;
  logic [XLEN-1:0]           opb;
  logic [XLEN-1:0]           step_sum;
  logic [XLEN-1:0]           acc;
  logic [XLEN-1:0]           pc_q;
  logic [SEQ_NUM_BITS-1:0]   seq_num_q;
  logic [4:0]                waddr_q;
  logic [PHYS_ADDR_BITS-1:0] preg_q;
  logic [PHYS_ADDR_BITS-1:0] ppreg_q;

  assign d_xfer = d.val & d.rdy;
  assign w_xfer = w.val & w.rdy;

  // One multiplier slice consumed per calc cycle
  assign step_en = (state == MUL_CALC);

  // ------------------------------
  // FSM
  // ------------------------------

  always_comb begin
    state_next = state;
    case (state)
      MUL_IDLE: if (d_xfer) state_next = MUL_CALC;
      // Final slice is added on this edge
      MUL_CALC: if (step_cnt == 6'(p_num_cycles - 1)) state_next = MUL_DONE;
      MUL_DONE: begin
        // New op may start in the cycle the result leaves
        if (w_xfer) begin
          state_next = d_xfer ? MUL_CALC : MUL_IDLE;
        end
      end
      default: state_next = MUL_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= MUL_IDLE;
      step_cnt <= '0;
    end else begin
      state <= state_next;
      if (d_xfer) begin
        step_cnt <= '0;
      end else if (step_en) begin
        step_cnt <= step_cnt + 6'd1;
      end
    end
  end

  // ------------------------------
  // Datapath
  // ------------------------------

  mul_step #(
    .num_bits (XLEN / p_num_cycles)
  ) u_step (
    .a   (opa),
    .b   (opb),
    .out (step_sum)
  );

  always_ff @(posedge clk) begin
    if (d_xfer) begin
      // Operands into shifters, accumulator cleared
      opa <= d.op2;
      opb <= d.op1;
      acc <= '0;
    end else if (step_en) begin
      opa <= opa >> (XLEN / p_num_cycles);
      opb <= opb << (XLEN / p_num_cycles);
      acc <= acc + step_sum;
    end
  end

  // Metadata captured on acceptance
  always_ff @(posedge clk) begin
    if (d_xfer) begin
      pc_q      <= d.pc;
      seq_num_q <= d.seq_num;
      waddr_q   <= d.waddr;
      preg_q    <= d.preg;
      ppreg_q   <= d.ppreg;
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------

  assign d.rdy = (state == MUL_IDLE) || ((state == MUL_DONE) && w.rdy);

  assign w.val     = (state == MUL_DONE);
  assign w.pc      = pc_q;
  assign w.seq_num = seq_num_q;
  assign w.waddr   = waddr_q;
  assign w.wdata   = acc;
  assign w.preg    = preg_q;
  assign w.ppreg   = ppreg_q;

endmodule

`default_nettype wire

//--- verilog/alu_unit.sv
/*
 * Single-cycle integer ALU
 * Registered output buffer that holds under back-pressure
 */
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
  input  logic   clk,
  input  logic   rst,
  dx_if.unit     d,
  xw_if.unit     w
);

  import exec_pkg::*;

  logic                      d_xfer;
  logic                      w_xfer;
  logic [XLEN-1:0]           result;
  logic                      val_q;
  logic [XLEN-1:0]           pc_q;
  logic [SEQ_NUM_BITS-1:0]   seq_num_q;
  logic [4:0]                waddr_q;
  logic [XLEN-1:0]           wdata_q;
  logic [PHYS_ADDR_BITS-1:0] preg_q;
  logic [PHYS_ADDR_BITS-1:0] ppreg_q;

  assign d_xfer = d.val & d.rdy;
  assign w_xfer = val_q & w.rdy;

  // Empty, or draining this cycle
  assign d.rdy = ~val_q | w.rdy;

  // ------------------------------
  // Decode and compute
  // ------------------------------

  always_comb begin
    case (d.uop)
      UOP_ADD: result = d.op1 + d.op2;
      UOP_SUB: result = d.op1 - d.op2;
      UOP_AND: result = d.op1 & d.op2;
      UOP_OR:  result = d.op1 | d.op2;
      UOP_XOR: result = d.op1 ^ d.op2;
      // Shift amount from op2[4:0]
      UOP_SLL: result = d.op1 << d.op2[4:0];
      UOP_SRL: result = d.op1 >> d.op2[4:0];
      default: result = '0;
    endcase
  end

  // ------------------------------
  // Output buffer
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      val_q <= 1'b0;
    end else if (d_xfer) begin
      val_q <= 1'b1;
    end else if (w_xfer) begin
      val_q <= 1'b0;
    end
  end

  // Payload only moves on a new op
  always_ff @(posedge clk) begin
    if (d_xfer) begin
      pc_q      <= d.pc;
      seq_num_q <= d.seq_num;
      waddr_q   <= d.waddr;
      wdata_q   <= result;
      preg_q    <= d.preg;
      ppreg_q   <= d.ppreg;
    end
  end

  assign w.val     = val_q;
  assign w.pc      = pc_q;
  assign w.seq_num = seq_num_q;
  assign w.waddr   = waddr_q;
  assign w.wdata   = wdata_q;
  assign w.preg    = preg_q;
  assign w.ppreg   = ppreg_q;

endmodule

`default_nettype wire

//--- verilog/exec_router.sv
/*
 * Steers micro-ops to the ALU or multiplier
 * Arbitrates completions onto one writeback port, multiplier first
 */
`timescale 1ns/100ps
`default_nettype none

module exec_router (
  dx_if.unit     d_in,
  dx_if.dispatch alu_in,
  dx_if.dispatch mul_in,
  xw_if.wb       alu_out,
  xw_if.wb       mul_out,
  xw_if.unit     w_out
);

  import exec_pkg::*;

  logic is_mul;
  logic mul_win;

  // ------------------------------
  // Dispatch steering
  // ------------------------------

  assign is_mul = (d_in.uop == UOP_MUL);

  // Only the selected unit sees val
  assign alu_in.val = d_in.val & ~is_mul;
  assign mul_in.val = d_in.val & is_mul;
  assign d_in.rdy   = is_mul ? mul_in.rdy : alu_in.rdy;

  // Payload fans out to both units
  assign alu_in.pc      = d_in.pc;
  assign alu_in.seq_num = d_in.seq_num;
  assign alu_in.waddr   = d_in.waddr;
  assign alu_in.uop     = d_in.uop;
  assign alu_in.op1     = d_in.op1;
  assign alu_in.op2     = d_in.op2;
  assign alu_in.preg    = d_in.preg;
  assign alu_in.ppreg   = d_in.ppreg;

  assign mul_in.pc      = d_in.pc;
  assign mul_in.seq_num = d_in.seq_num;
  assign mul_in.waddr   = d_in.waddr;
  assign mul_in.uop     = d_in.uop;
  assign mul_in.op1     = d_in.op1;
  assign mul_in.op2     = d_in.op2;
  assign mul_in.preg    = d_in.preg;
  assign mul_in.ppreg   = d_in.ppreg;

  // ------------------------------
  // Completion arbitration
  // ------------------------------

  // Multiplier has priority, ALU holds its result
  assign mul_win = mul_out.val;

  assign mul_out.rdy = w_out.rdy;
  assign alu_out.rdy = w_out.rdy & ~mul_win;

  assign w_out.val     = mul_out.val | alu_out.val;
  assign w_out.pc      = mul_win ? mul_out.pc      : alu_out.pc;
  assign w_out.seq_num = mul_win ? mul_out.seq_num : alu_out.seq_num;
  assign w_out.waddr   = mul_win ? mul_out.waddr   : alu_out.waddr;
  assign w_out.wdata   = mul_win ? mul_out.wdata   : alu_out.wdata;
  assign w_out.preg    = mul_win ? mul_out.preg    : alu_out.preg;
  assign w_out.ppreg   = mul_win ? mul_out.ppreg   : alu_out.ppreg;

  // x0 is never written
  assign w_out.wen = (w_out.waddr != 5'd0);

endmodule

`default_nettype wire

//--- verilog/exec_stage.sv
/*
 * Execute stage top level
 * Router, ALU and iterative multiplier behind plain ports
 */
`timescale 1ns/100ps
`default_nettype none

module exec_stage (
  input  logic                                clk,
  input  logic                                rst,
  // Dispatch side
  input  logic                                d_val,
  output logic                                d_rdy,
  input  logic [exec_pkg::XLEN-1:0]           d_pc,
  input  logic [exec_pkg::SEQ_NUM_BITS-1:0]   d_seq_num,
  input  logic [4:0]                          d_waddr,
  input  logic [exec_pkg::UOP_BITS-1:0]       d_uop,
  input  logic [exec_pkg::XLEN-1:0]           d_op1,
  input  logic [exec_pkg::XLEN-1:0]           d_op2,
  input  logic [exec_pkg::PHYS_ADDR_BITS-1:0] d_preg,
  input  logic [exec_pkg::PHYS_ADDR_BITS-1:0] d_ppreg,
  // Writeback side
  output logic                                w_val,
  input  logic                                w_rdy,
  output logic [exec_pkg::XLEN-1:0]           w_pc,
  output logic [exec_pkg::SEQ_NUM_BITS-1:0]   w_seq_num,
  output logic [4:0]                          w_waddr,
  output logic [exec_pkg::XLEN-1:0]           w_wdata,
  output logic                                w_wen,
  output logic [exec_pkg::PHYS_ADDR_BITS-1:0] w_preg,
  output logic [exec_pkg::PHYS_ADDR_BITS-1:0] w_ppreg
);

  // Links between router and units
  dx_if d_link ();
  dx_if alu_d_link ();
  dx_if mul_d_link ();
  xw_if alu_w_link ();
  xw_if mul_w_link ();
  xw_if w_link ();

  // ------------------------------
  // Outer ports
  // ------------------------------

  assign d_link.val     = d_val;
  assign d_link.pc      = d_pc;
  assign d_link.seq_num = d_seq_num;
  assign d_link.waddr   = d_waddr;
  assign d_link.uop     = d_uop;
  assign d_link.op1     = d_op1;
  assign d_link.op2     = d_op2;
  assign d_link.preg    = d_preg;
  assign d_link.ppreg   = d_ppreg;
  assign d_rdy          = d_link.rdy;

  assign w_val      = w_link.val;
  assign w_pc       = w_link.pc;
  assign w_seq_num  = w_link.seq_num;
  assign w_waddr    = w_link.waddr;
  assign w_wdata    = w_link.wdata;
  assign w_wen      = w_link.wen;
  assign w_preg     = w_link.preg;
  assign w_ppreg    = w_link.ppreg;
  assign w_link.rdy = w_rdy;

  // ------------------------------
  // Units
  // ------------------------------

  exec_router u_router (
    .d_in    (d_link),
    .alu_in  (alu_d_link),
    .mul_in  (mul_d_link),
    .alu_out (alu_w_link),
    .mul_out (mul_w_link),
    .w_out   (w_link)
  );

  alu_unit u_alu (
    .clk (clk),
    .rst (rst),
    .d   (alu_d_link),
    .w   (alu_w_link)
  );

  // 4 multiplier bits per calc cycle
  iter_multiplier #(
    .p_num_cycles (8)
  ) u_mul (
    .clk (clk),
    .rst (rst),
    .d   (mul_d_link),
    .w   (mul_w_link)
  );

endmodule

`default_nettype wire

//--- testbench/exec_stage_tb.sv
/*
 * Directed testbench for the execute stage
 * Clock, reset, driver and monitor tasks, check task, result model
 */
`timescale 1ns/100ps
`default_nettype none

module exec_stage_tb;

  import exec_pkg::*;

  localparam int ACCEPT_LIMIT = 64;
  localparam int RESULT_LIMIT = 64;
  localparam int STREAM_LIMIT = 4000;
  localparam int STREAM_OPS   = 24;
  localparam int MUL_LATENCY  = 9;
  localparam int NUM_SEQ      = 2 ** SEQ_NUM_BITS;

  logic                      clk;
  logic                      rst;
  logic                      d_val;
  logic                      d_rdy;
  logic [XLEN-1:0]           d_pc;
  logic [SEQ_NUM_BITS-1:0]   d_seq_num;
  logic [4:0]                d_waddr;
  logic [UOP_BITS-1:0]       d_uop;
  logic [XLEN-1:0]           d_op1;
  logic [XLEN-1:0]           d_op2;
  logic [PHYS_ADDR_BITS-1:0] d_preg;
  logic [PHYS_ADDR_BITS-1:0] d_ppreg;
  logic                      w_val;
  logic                      w_rdy;
  logic [XLEN-1:0]           w_pc;
  logic [SEQ_NUM_BITS-1:0]   w_seq_num;
  logic [4:0]                w_waddr;
  logic [XLEN-1:0]           w_wdata;
  logic                      w_wen;
  logic [PHYS_ADDR_BITS-1:0] w_preg;
  logic [PHYS_ADDR_BITS-1:0] w_ppreg;

  integer                    seed;
  logic [SEQ_NUM_BITS-1:0]   next_seq;

  // Expected results by seq_num
  logic [XLEN-1:0]           exp_pc    [NUM_SEQ];
  logic [4:0]                exp_waddr [NUM_SEQ];
  logic [XLEN-1:0]           exp_wdata [NUM_SEQ];
  logic [PHYS_ADDR_BITS-1:0] exp_preg  [NUM_SEQ];
  logic [PHYS_ADDR_BITS-1:0] exp_ppreg [NUM_SEQ];
  logic                      pending   [NUM_SEQ];

  // ALU codes first, multiply last
  logic [UOP_BITS-1:0] all_codes [8] = '{UOP_ADD, UOP_SUB, UOP_AND, UOP_OR,
                                         UOP_XOR, UOP_SLL, UOP_SRL, UOP_MUL};

  always #50 clk = ~clk;

  exec_stage dut (
    .clk       (clk),
    .rst       (rst),
    .d_val     (d_val),
    .d_rdy     (d_rdy),
    .d_pc      (d_pc),
    .d_seq_num (d_seq_num),
    .d_waddr   (d_waddr),
    .d_uop     (d_uop),
    .d_op1     (d_op1),
    .d_op2     (d_op2),
    .d_preg    (d_preg),
    .d_ppreg   (d_ppreg),
    .w_val     (w_val),
    .w_rdy     (w_rdy),
    .w_pc      (w_pc),
    .w_seq_num (w_seq_num),
    .w_waddr   (w_waddr),
    .w_wdata   (w_wdata),
    .w_wen     (w_wen),
    .w_preg    (w_preg),
    .w_ppreg   (w_ppreg)
  );

  // ------------------------------
  // Model and helpers
  // ------------------------------

  // Wrapping 32-bit arithmetic, shifts by b[4:0]
  function automatic logic [XLEN-1:0] model_result(input logic [UOP_BITS-1:0] uop,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
    case (uop)
      UOP_ADD: model_result = a + b;
      UOP_SUB: model_result = a - b;
      UOP_AND: model_result = a & b;
      UOP_OR:  model_result = a | b;
      UOP_XOR: model_result = a ^ b;
      UOP_SLL: model_result = a << b[4:0];
      UOP_SRL: model_result = a >> b[4:0];
      UOP_MUL: model_result = a * b;
      default: model_result = '0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] rand32();
    logic [XLEN-1:0] r;
    r = $random(seed);
    return r;
  endfunction

  function automatic logic [4:0] rand_waddr();
    logic [XLEN-1:0] r;
    r = rand32();
    return r[4:0];
  endfunction

  task automatic check_equal(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    $display("tests failed");
    $fatal(1, "wait timed out");
  endtask

  // Called on a falling edge, holds d_val high afterwards
  task automatic present_uop(input logic [UOP_BITS-1:0] uop, input logic [XLEN-1:0] op1,
                             input logic [XLEN-1:0] op2, input logic [4:0] waddr,
                             input logic [SEQ_NUM_BITS-1:0] seq);
    logic [XLEN-1:0] r;
    r = rand32();
    d_pc      = {r[XLEN-1:2], 2'b00};
    d_seq_num = seq;
    d_waddr   = waddr;
    d_uop     = uop;
    d_op1     = op1;
    d_op2     = op2;
    r = rand32();
    d_preg    = r[PHYS_ADDR_BITS-1:0];
    d_ppreg   = r[PHYS_ADDR_BITS+7:8];
    d_val     = 1'b1;
    exp_pc[seq]    = d_pc;
    exp_waddr[seq] = waddr;
    exp_wdata[seq] = model_result(uop, op1, op2);
    exp_preg[seq]  = d_preg;
    exp_ppreg[seq] = d_ppreg;
    pending[seq]   = 1'b1;
  endtask

  // Returns on the accepting rising edge
  task automatic wait_accept();
    int n;
    n = 0;
    #1;
    while (d_rdy !== 1'b1) begin
      if (n >= ACCEPT_LIMIT) begin
        report_timeout("d_rdy");
      end else begin
        n++;
        @(negedge clk);
        #1;
      end
    end
    @(posedge clk);
  endtask

  // Starts on the first falling edge after acceptance
  task automatic wait_result(output int cycles);
    cycles = 1;
    #1;
    while (w_val !== 1'b1) begin
      if (cycles >= RESULT_LIMIT) begin
        report_timeout("w_val");
      end else begin
        cycles++;
        @(negedge clk);
        #1;
      end
    end
  endtask

  // Compares the writeback port with the model, take marks it delivered
  task automatic check_result(input logic take);
    logic [SEQ_NUM_BITS-1:0] s;
    s = w_seq_num;
    if (pending[s] !== 1'b1) begin
      $display("Unexpected or repeated result for seq_num %0d at %0t", s, $time);
      $display("tests failed");
      $fatal(1, "bad completion");
    end
    check_equal("w_pc", w_pc, exp_pc[s]);
    check_equal("w_waddr", 32'(w_waddr), 32'(exp_waddr[s]));
    check_equal("w_wdata", w_wdata, exp_wdata[s]);
    // wen follows waddr
    check_equal("w_wen", 32'(w_wen), 32'(exp_waddr[s] != 5'd0));
    check_equal("w_preg", 32'(w_preg), 32'(exp_preg[s]));
    check_equal("w_ppreg", 32'(w_ppreg), 32'(exp_ppreg[s]));
    if (take) begin
      pending[s] = 1'b0;
    end
  endtask

  // One op end to end with w_rdy high
  task automatic run_op(input logic [UOP_BITS-1:0] uop, input logic [XLEN-1:0] op1,
                        input logic [XLEN-1:0] op2, input logic [4:0] waddr,
                        input int exp_lat);
    int cycles;
    @(negedge clk);
    present_uop(uop, op1, op2, waddr, next_seq);
    next_seq++;
    wait_accept();
    @(negedge clk);
    d_val = 1'b0;
    wait_result(cycles);
    check_equal("w_val latency", 32'(cycles), 32'(exp_lat));
    check_result(1'b1);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  // Writeback stalled, so d_rdy only shows whether each unit is empty
  task automatic check_reset_state();
    w_rdy = 1'b0;
    d_uop = UOP_ADD;
    #1;
    check_equal("w_val", 32'(w_val), 32'd0);
    check_equal("d_rdy alu", 32'(d_rdy), 32'd1);
    @(negedge clk);
    d_uop = UOP_MUL;
    #1;
    check_equal("w_val", 32'(w_val), 32'd0);
    check_equal("d_rdy mul", 32'(d_rdy), 32'd1);
    @(negedge clk);
    d_uop = UOP_ADD;
    w_rdy = 1'b1;
  endtask

  task automatic run_alu_ops();
    for (int i = 0; i < 7; i++) begin
      run_op(all_codes[i], 32'd0, 32'd0, 5'd1, 1);
      run_op(all_codes[i], '1, '1, 5'd2, 1);
      // Shift amounts 0 and 31, upper op2 bits ignored
      run_op(all_codes[i], rand32(), 32'd0, rand_waddr(), 1);
      run_op(all_codes[i], rand32(), 32'd31, rand_waddr(), 1);
      run_op(all_codes[i], rand32(), 32'hffff_ffe3, rand_waddr(), 1);
      repeat (4) run_op(all_codes[i], rand32(), rand32(), rand_waddr(), 1);
    end
  endtask

  task automatic run_multiplies();
    run_op(UOP_MUL, 32'd0, rand32(), rand_waddr(), MUL_LATENCY);
    run_op(UOP_MUL, rand32(), 32'd0, rand_waddr(), MUL_LATENCY);
    run_op(UOP_MUL, 32'd1, rand32(), rand_waddr(), MUL_LATENCY);
    run_op(UOP_MUL, rand32(), 32'd1, rand_waddr(), MUL_LATENCY);
    run_op(UOP_MUL, '1, '1, rand_waddr(), MUL_LATENCY);
    run_op(UOP_MUL, '1, rand32(), rand_waddr(), MUL_LATENCY);
    run_op(UOP_MUL, 32'h8000_0000, 32'd2, rand_waddr(), MUL_LATENCY);
    repeat (6) run_op(UOP_MUL, rand32(), rand32(), rand_waddr(), MUL_LATENCY);
  endtask

  task automatic check_wen_rule();
    run_op(UOP_ADD, rand32(), rand32(), 5'd0, 1);
    run_op(UOP_XOR, rand32(), rand32(), 5'd31, 1);
    run_op(UOP_MUL, rand32(), rand32(), 5'd0, MUL_LATENCY);
    run_op(UOP_MUL, rand32(), rand32(), 5'd17, MUL_LATENCY);
  endtask

  // Second op of the same unit must stall until the first leaves
  task automatic apply_back_pressure(input logic [UOP_BITS-1:0] uop);
    logic [SEQ_NUM_BITS-1:0] first_seq;
    logic [SEQ_NUM_BITS-1:0] second_seq;
    int                      cycles;
    @(negedge clk);
    w_rdy = 1'b0;
    first_seq = next_seq;
    present_uop(uop, rand32(), rand32(), rand_waddr(), next_seq);
    next_seq++;
    wait_accept();
    @(negedge clk);
    second_seq = next_seq;
    present_uop(uop, rand32(), rand32(), rand_waddr(), next_seq);
    next_seq++;
    wait_result(cycles);
    check_equal("w_seq_num", 32'(w_seq_num), 32'(first_seq));
    // Held result stays put
    repeat (4) begin
      @(negedge clk);
      #1;
      check_equal("w_val", 32'(w_val), 32'd1);
      check_equal("w_seq_num", 32'(w_seq_num), 32'(first_seq));
      check_equal("d_rdy", 32'(d_rdy), 32'd0);
      check_result(1'b0);
    end
    @(negedge clk);
    w_rdy = 1'b1;
    #1;
    // Drain and accept on the same edge
    check_equal("d_rdy", 32'(d_rdy), 32'd1);
    check_result(1'b1);
    @(posedge clk);
    @(negedge clk);
    d_val = 1'b0;
    wait_result(cycles);
    check_equal("w_val latency", 32'(cycles), (uop == UOP_MUL) ? MUL_LATENCY : 1);
    check_equal("w_seq_num", 32'(w_seq_num), 32'(second_seq));
    check_result(1'b1);
    @(negedge clk);
    #1;
    check_equal("w_val", 32'(w_val), 32'd0);
  endtask

  // Random ops against random w_rdy, matched by seq_num
  task automatic run_mixed_stream();
    next_seq = '0;
    fork
      begin
        logic [XLEN-1:0] r;
        for (int i = 0; i < STREAM_OPS; i++) begin
          @(negedge clk);
          r = rand32();
          present_uop(all_codes[r[2:0]], rand32(), rand32(), rand_waddr(), next_seq);
          next_seq++;
          wait_accept();
        end
        @(negedge clk);
        d_val = 1'b0;
      end
      begin
        logic [XLEN-1:0] r;
        logic            next_rdy;
        int              received;
        int              n;
        received = 0;
        n = 0;
        next_rdy = 1'b1;
        while (received < STREAM_OPS) begin
          if (n >= STREAM_LIMIT) begin
            report_timeout("stream results");
          end else begin
            @(negedge clk);
            w_rdy = next_rdy;
            #1;
            if (w_val && w_rdy) begin
              check_result(1'b1);
              received++;
            end
            // Drawn after sampling so seed use stays ordered
            r = rand32();
            next_rdy = (r[1:0] != 2'b00);
            n++;
          end
        end
        @(negedge clk);
        w_rdy = 1'b1;
      end
    join
    for (int s = 0; s < NUM_SEQ; s++) begin
      check_equal("pending after stream", 32'(pending[s]), 32'd0);
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    seed      = 32'h7bde;
    clk       = 1'b0;
    rst       = 1'b1;
    d_val     = 1'b0;
    d_pc      = '0;
    d_seq_num = '0;
    d_waddr   = '0;
    d_uop     = UOP_ADD;
    d_op1     = '0;
    d_op2     = '0;
    d_preg    = '0;
    d_ppreg   = '0;
    w_rdy     = 1'b1;
    next_seq  = '0;
    for (int s = 0; s < NUM_SEQ; s++) begin
      pending[s] = 1'b0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_reset_state();
    run_alu_ops();
    run_multiplies();
    check_wen_rule();
    apply_back_pressure(UOP_ADD);
    apply_back_pressure(UOP_MUL);
    run_mixed_stream();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
verilog/exec_pkg.sv
verilog/dx_if.sv
verilog/xw_if.sv
verilog/mul_step.sv
verilog/iter_multiplier.sv
verilog/alu_unit.sv
verilog/exec_router.sv
verilog/exec_stage.sv
testbench/exec_stage_tb.sv

//--- run.sh
#!/bin/sh
# Build the execute stage testbench with Verilator and run it.
# A failing test ends in $fatal, which gives a nonzero exit status.
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps \
  --top-module exec_stage_tb -f src.f -o exec_stage_sim &&
./obj_dir/exec_stage_sim || exit 1
